/* tb.f */
logic/bedrock_pkg.sv
logic/msg_fifo.sv
logic/nbf_loader.sv
logic/mem_router.sv
logic/dram_slice.sv
logic/host_regs.sv
logic/boot_host_top.sv
tests/boot_host_sva.sv
tests/boot_host_tb.sv

/* tests/boot_host_tb.sv */
`timescale 1ns/1ps

module boot_host_tb;

  localparam int clk_period_ns = 40;
  localparam int reset_cycles = 5;
  localparam int fill_count = 16;
  localparam int mixed_count = 200;
  localparam int host_count = 6;
  localparam int heavy_count = 400;
  localparam int total_records = fill_count + mixed_count + host_count + heavy_count + 1;
  localparam int cycles_per_record = 20;

  logic                                clk_i;
  logic                                rst_i;
  bedrock_pkg::nbf_record_s            record_i;
  logic                                record_v_i;
  logic                                record_ready_o;
  logic                                rd_v_o;
  logic [bedrock_pkg::paddr_width-1:0] rd_addr_o;
  logic [bedrock_pkg::data_width-1:0]  rd_data_o;
  logic                                done_o;
  logic [bedrock_pkg::trace_width-1:0] trace_en_o;
  logic [bedrock_pkg::num_core-1:0]    finish_o;

  integer seed = 32'h178;
  string  test_name = "reset";
  logic   finish_sent = 1'b0;
  int     reads_issued = 0;
  int     reads_seen = 0;

  // Reference model, updated in record order
  logic [63:0] model_mem [16];
  logic [7:0]  model_trace = '0;
  logic [3:0]  model_finish = '0;
  logic [bedrock_pkg::paddr_width-1:0] exp_addr_q [$];
  logic [63:0]                         exp_data_q [$];

  boot_host_top boot_host_top_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .record_i(record_i), .record_v_i(record_v_i), .record_ready_o(record_ready_o),
      .rd_v_o(rd_v_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o), .done_o(done_o),
      .trace_en_o(trace_en_o), .finish_o(finish_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_ns / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(total_records * cycles_per_record * clk_period_ns);
    report_failure("Run timed out before all records were handled");
  end

  task automatic report_failure(input string reason);
    begin
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic check_value(input string label, input logic [63:0] expected,
                             input logic [63:0] actual);
    begin
      if (actual !== expected)
      begin
        report_failure($sformatf("Fail %s %s: expected %h, actual %h",
                                 test_name, label, expected, actual));
      end
    end
  endtask

  function automatic logic [63:0] random_word();
    random_word = {$random(seed), $random(seed)};
  endfunction

  function automatic int random_below(input int n);
    random_below = $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [19:0] mem_addr(input int idx);
    mem_addr = 20'(idx) << 3;
  endfunction

  function automatic logic [19:0] host_addr(input logic [3:0] offset);
    host_addr = (20'd1 << bedrock_pkg::host_region_bit) | 20'(offset);
  endfunction

  function automatic logic [63:0] expected_read(input logic [19:0] addr);
    if (addr[bedrock_pkg::host_region_bit])
    begin
      case (addr[3:0])
        4'h0: expected_read = {56'b0, model_trace};
        4'h8: expected_read = {60'b0, model_finish};
        default: expected_read = '0;
      endcase
    end
    else
    begin
      expected_read = model_mem[addr[6:3]];
    end
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_record(input bedrock_pkg::nbf_op_e op, input logic [19:0] addr,
                             input logic [63:0] data);
    logic taken;
    begin
      record_i.op = op;
      record_i.addr = addr;
      record_i.data = data;
      record_v_i = 1'b1;
      taken = 1'b0;
      while (!taken)
      begin
        #1;
        taken = record_ready_o;
        @(negedge clk_i);
      end
      record_v_i = 1'b0;
    end
  endtask

  task automatic issue_write(input logic [19:0] addr, input logic [63:0] data);
    begin
      if (addr[bedrock_pkg::host_region_bit])
      begin
        if (addr[3:0] == 4'h0)
        begin
          model_trace = data[7:0];
        end
        else if (addr[3:0] == 4'h8)
        begin
          model_finish = data[3:0];
        end
      end
      else
      begin
        model_mem[addr[6:3]] = data;
      end
      send_record(bedrock_pkg::e_nbf_write, addr, data);
    end
  endtask

  task automatic issue_read(input logic [19:0] addr);
    begin
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(expected_read(addr));
      reads_issued++;
      send_record(bedrock_pkg::e_nbf_read, addr, random_word());
    end
  endtask

  task automatic wait_for_reads();
    begin
      while (exp_addr_q.size() != 0)
      begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic check_read_result();
    logic [bedrock_pkg::paddr_width-1:0] exp_addr;
    logic [63:0]                         exp_data;
    begin
      if (exp_addr_q.size() == 0)
      begin
        report_failure("Read result strobe seen with no read outstanding");
      end
      else
      begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        check_value("rd_addr_o", 64'(exp_addr), 64'(rd_addr_o));
        check_value("rd_data_o", exp_data, rd_data_o);
        reads_seen++;
      end
    end
  endtask

  // Results first, then done, so the last read is counted before done is judged
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (rd_v_o)
      begin
        check_read_result();
      end
      if (done_o)
      begin
        check_value("done_o_before_finish", 64'd1, 64'(finish_sent));
        check_value("reads_pending_at_done", 64'd0, 64'(exp_addr_q.size()));
      end
    end
  end

  initial
  begin
    int sel;
    rst_i = 1'b1;
    record_i = '0;
    record_v_i = 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    check_value("rd_v_o", 64'd0, 64'(rd_v_o));
    check_value("done_o", 64'd0, 64'(done_o));
    check_value("trace_en_o", 64'd0, 64'(trace_en_o));
    check_value("finish_o", 64'd0, 64'(finish_o));
    check_value("record_ready_o", 64'd1, 64'(record_ready_o));

    test_name = "mem_fill";
    for (int i = 0; i < fill_count; i++)
    begin
      issue_write(mem_addr(i), random_word());
    end

    test_name = "mem_mixed";
    for (int n = 0; n < mixed_count; n++)
    begin
      if (random_below(2) == 0)
      begin
        issue_read(mem_addr(random_below(16)));
      end
      else
      begin
        issue_write(mem_addr(random_below(16)), random_word());
      end
      if (random_below(4) == 0)
      begin
        @(negedge clk_i);
      end
    end
    wait_for_reads();

    test_name = "host_trace";
    issue_write(host_addr(bedrock_pkg::host_trace_offset), random_word());
    issue_read(host_addr(bedrock_pkg::host_trace_offset));
    wait_for_reads();
    check_value("trace_en_o", 64'(model_trace), 64'(trace_en_o));

    test_name = "host_finish";
    issue_write(host_addr(bedrock_pkg::host_finish_offset), random_word());
    issue_read(host_addr(bedrock_pkg::host_finish_offset));
    issue_read(host_addr(4'h4));
    issue_read(host_addr(4'hc));
    wait_for_reads();
    check_value("finish_o", 64'(model_finish), 64'(finish_o));

    // Back to back records, no idle cycles
    test_name = "heavy_traffic";
    for (int n = 0; n < heavy_count; n++)
    begin
      sel = random_below(8);
      if (sel == 0)
      begin
        issue_write(host_addr(bedrock_pkg::host_trace_offset), random_word());
      end
      else if (sel == 1)
      begin
        issue_read(host_addr(bedrock_pkg::host_trace_offset));
      end
      else if (sel < 5)
      begin
        issue_read(mem_addr(random_below(16)));
      end
      else
      begin
        issue_write(mem_addr(random_below(16)), random_word());
      end
    end

    test_name = "finish";
    finish_sent = 1'b1;
    send_record(bedrock_pkg::e_nbf_finish, '0, '0);
    while (!done_o)
    begin
      @(negedge clk_i);
    end
    // Final strobe can share its edge with done
    @(negedge clk_i);
    check_value("read_count", 64'(reads_issued), 64'(reads_seen));

    // Loader must refuse anything after finish
    record_i.op = bedrock_pkg::e_nbf_write;
    record_v_i = 1'b1;
    repeat (10)
    begin
      @(negedge clk_i);
      #1;
      check_value("record_ready_o", 64'd0, 64'(record_ready_o));
      check_value("done_o", 64'd1, 64'(done_o));
    end
    record_v_i = 1'b0;
    check_value("trace_en_o", 64'(model_trace), 64'(trace_en_o));
    check_value("finish_o", 64'(model_finish), 64'(finish_o));

    $display("TEST OK");
    $finish;
  end

endmodule

/* tests/boot_host_sva.sv */
`timescale 1ns/1ps

module boot_host_sva
  (
    input logic clk_i,
    input logic rst_i,
    input logic rd_v_i,
    input logic done_i
  );

  // Done is sticky until reset
  done_sticky: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> done_i)
    else $error("done_o fell without reset");

  // Checked from the second reset cycle, once the strobe register is cleared
  no_read_in_reset: assert property (@(posedge clk_i) (rst_i ##1 rst_i) |-> !rd_v_i)
    else $error("rd_v_o high during reset");

  // Nothing left to report once drained
  no_read_after_done: assert property
    (@(posedge clk_i) disable iff (rst_i) done_i |=> !rd_v_i)
    else $error("rd_v_o high after done_o was already high");

endmodule

bind boot_host_top boot_host_sva boot_host_sva_inst
  (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .rd_v_i(rd_v_o),
    .done_i(done_o)
  );

/* logic/boot_host_top.sv */
`timescale 1ns/1ps

module boot_host_top
  (
    input  logic                                clk_i,
    input  logic                                rst_i,

    input  bedrock_pkg::nbf_record_s            record_i,
    input  logic                                record_v_i,
    output logic                                record_ready_o,

    output logic                                rd_v_o,
    output logic [bedrock_pkg::paddr_width-1:0] rd_addr_o,
    output logic [bedrock_pkg::data_width-1:0]  rd_data_o,
    output logic                                done_o,

    output logic [bedrock_pkg::trace_width-1:0] trace_en_o,
    output logic [bedrock_pkg::num_core-1:0]    finish_o
  );

  // Loader side of the FIFOs
  bedrock_pkg::mem_fwd_s ld_fwd;
  logic                  ld_fwd_v, ld_fwd_ready;
  bedrock_pkg::mem_rev_s ld_rev;
  logic                  ld_rev_v, ld_rev_ready;

  // Router side of the FIFOs
  bedrock_pkg::mem_fwd_s rt_fwd;
  logic                  rt_fwd_v, rt_fwd_ready;
  bedrock_pkg::mem_rev_s rt_rev;
  logic                  rt_rev_v, rt_rev_ready;

  // Targets
  bedrock_pkg::mem_fwd_s mem_fwd, host_fwd;
  logic                  mem_fwd_v, mem_fwd_ready, host_fwd_v, host_fwd_ready;
  bedrock_pkg::mem_rev_s mem_rev, host_rev;
  logic                  mem_rev_v, mem_rev_ready, host_rev_v, host_rev_ready;

  nbf_loader nbf_loader_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .record_i(record_i), .record_v_i(record_v_i), .record_ready_o(record_ready_o),
      .fwd_o(ld_fwd), .fwd_v_o(ld_fwd_v), .fwd_ready_i(ld_fwd_ready),
      .rev_i(ld_rev), .rev_v_i(ld_rev_v), .rev_ready_o(ld_rev_ready),
      .rd_v_o(rd_v_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
      .done_o(done_o)
    );

  msg_fifo #(.msg_t(bedrock_pkg::mem_fwd_s)) fwd_fifo_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .data_i(ld_fwd), .v_i(ld_fwd_v), .ready_o(ld_fwd_ready),
      .data_o(rt_fwd), .v_o(rt_fwd_v), .ready_i(rt_fwd_ready)
    );

  msg_fifo #(.msg_t(bedrock_pkg::mem_rev_s)) rev_fifo_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .data_i(rt_rev), .v_i(rt_rev_v), .ready_o(rt_rev_ready),
      .data_o(ld_rev), .v_o(ld_rev_v), .ready_i(ld_rev_ready)
    );

  mem_router mem_router_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .fwd_i(rt_fwd), .fwd_v_i(rt_fwd_v), .fwd_ready_o(rt_fwd_ready),
      .mem_fwd_o(mem_fwd), .mem_fwd_v_o(mem_fwd_v), .mem_fwd_ready_i(mem_fwd_ready),
      .host_fwd_o(host_fwd), .host_fwd_v_o(host_fwd_v), .host_fwd_ready_i(host_fwd_ready),
      .mem_rev_i(mem_rev), .mem_rev_v_i(mem_rev_v), .mem_rev_ready_o(mem_rev_ready),
      .host_rev_i(host_rev), .host_rev_v_i(host_rev_v), .host_rev_ready_o(host_rev_ready),
      .rev_o(rt_rev), .rev_v_o(rt_rev_v), .rev_ready_i(rt_rev_ready)
    );

  dram_slice dram_slice_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .fwd_i(mem_fwd), .fwd_v_i(mem_fwd_v), .fwd_ready_o(mem_fwd_ready),
      .rev_o(mem_rev), .rev_v_o(mem_rev_v), .rev_ready_i(mem_rev_ready)
    );

  host_regs host_regs_inst
    (
      .clk_i(clk_i), .rst_i(rst_i),
      .fwd_i(host_fwd), .fwd_v_i(host_fwd_v), .fwd_ready_o(host_fwd_ready),
      .rev_o(host_rev), .rev_v_o(host_rev_v), .rev_ready_i(host_rev_ready),
      .trace_en_o(trace_en_o), .finish_o(finish_o)
    );

endmodule

/* logic/host_regs.sv */
`timescale 1ns/1ps

module host_regs
  (
    input  logic                                clk_i,
    input  logic                                rst_i,

    input  bedrock_pkg::mem_fwd_s               fwd_i,
    input  logic                                fwd_v_i,
    output logic                                fwd_ready_o,

    output bedrock_pkg::mem_rev_s               rev_o,
    output logic                                rev_v_o,
    input  logic                                rev_ready_i,

    output logic [bedrock_pkg::trace_width-1:0] trace_en_o,
    output logic [bedrock_pkg::num_core-1:0]    finish_o
  );

  logic [bedrock_pkg::host_offset_width-1:0] offset;
  logic [bedrock_pkg::data_width-1:0]        rd_val;
  logic                                      accept;
  logic                                      is_write;

  assign offset = fwd_i.addr[bedrock_pkg::host_offset_width-1:0];
  assign is_write = (fwd_i.msg_type == bedrock_pkg::e_msg_write);

  assign fwd_ready_o = ~rev_v_o | rev_ready_i;
  assign accept = fwd_v_i & fwd_ready_o;

  // Unmapped offsets read as zero
  always_comb
  begin
    rd_val = '0;
    if (offset == bedrock_pkg::host_trace_offset)
    begin
      rd_val[bedrock_pkg::trace_width-1:0] = trace_en_o;
    end
    else if (offset == bedrock_pkg::host_finish_offset)
    begin
      rd_val[bedrock_pkg::num_core-1:0] = finish_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      trace_en_o <= '0;
      finish_o <= '0;
      rev_v_o <= 1'b0;
    end
    else
    begin
      if (accept & is_write & (offset == bedrock_pkg::host_trace_offset))
      begin
        trace_en_o <= fwd_i.data[bedrock_pkg::trace_width-1:0];
      end
      if (accept & is_write & (offset == bedrock_pkg::host_finish_offset))
      begin
        finish_o <= fwd_i.data[bedrock_pkg::num_core-1:0];
      end
      if (accept)
      begin
        rev_v_o <= 1'b1;
      end
      else if (rev_ready_i)
      begin
        rev_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rev_o.msg_type <= fwd_i.msg_type;
      rev_o.addr <= fwd_i.addr;
      rev_o.data <= is_write ? fwd_i.data : rd_val;
    end
  end

endmodule

/* logic/dram_slice.sv */
`timescale 1ns/1ps

module dram_slice
  (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  bedrock_pkg::mem_fwd_s fwd_i,
    input  logic                  fwd_v_i,
    output logic                  fwd_ready_o,

    output bedrock_pkg::mem_rev_s rev_o,
    output logic                  rev_v_o,
    input  logic                  rev_ready_i
  );

  logic [bedrock_pkg::data_width-1:0]      mem [bedrock_pkg::mem_words];
  logic [bedrock_pkg::mem_index_width-1:0] index;
  logic                                    accept;
  logic                                    is_write;

  assign index = fwd_i.addr[bedrock_pkg::mem_index_lsb +: bedrock_pkg::mem_index_width];
  assign is_write = (fwd_i.msg_type == bedrock_pkg::e_msg_write);

  // Room when the reply slot is free or draining
  assign fwd_ready_o = ~rev_v_o | rev_ready_i;
  assign accept = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (accept & is_write)
    begin
      mem[index] <= fwd_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rev_o.msg_type <= fwd_i.msg_type;
      rev_o.addr <= fwd_i.addr;
      rev_o.data <= is_write ? fwd_i.data : mem[index];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rev_v_o <= 1'b0;
    end
    else if (accept)
    begin
      rev_v_o <= 1'b1;
    end
    else if (rev_ready_i)
    begin
      rev_v_o <= 1'b0;
    end
  end

endmodule

/* logic/mem_router.sv */
`timescale 1ns/1ps

module mem_router
  (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  bedrock_pkg::mem_fwd_s fwd_i,
    input  logic                  fwd_v_i,
    output logic                  fwd_ready_o,

    output bedrock_pkg::mem_fwd_s mem_fwd_o,
    output logic                  mem_fwd_v_o,
    input  logic                  mem_fwd_ready_i,

    output bedrock_pkg::mem_fwd_s host_fwd_o,
    output logic                  host_fwd_v_o,
    input  logic                  host_fwd_ready_i,

    input  bedrock_pkg::mem_rev_s mem_rev_i,
    input  logic                  mem_rev_v_i,
    output logic                  mem_rev_ready_o,

    input  bedrock_pkg::mem_rev_s host_rev_i,
    input  logic                  host_rev_v_i,
    output logic                  host_rev_ready_o,

    output bedrock_pkg::mem_rev_s rev_o,
    output logic                  rev_v_o,
    input  logic                  rev_ready_i
  );

  logic to_host;
  logic host_sel;
  logic host_pri_r;
  logic mem_xfer;
  logic host_xfer;

  // Forward steering
  assign to_host = fwd_i.addr[bedrock_pkg::host_region_bit];

  assign mem_fwd_o = fwd_i;
  assign host_fwd_o = fwd_i;
  assign mem_fwd_v_o = fwd_v_i & ~to_host;
  assign host_fwd_v_o = fwd_v_i & to_host;
  assign fwd_ready_o = to_host ? host_fwd_ready_i : mem_fwd_ready_i;

  // Memory wins unless a host reply has been waiting
  assign host_sel = host_rev_v_i & (host_pri_r | ~mem_rev_v_i);

  assign rev_o = host_sel ? host_rev_i : mem_rev_i;
  assign rev_v_o = mem_rev_v_i | host_rev_v_i;
  assign mem_rev_ready_o = rev_ready_i & ~host_sel;
  assign host_rev_ready_o = rev_ready_i & host_sel;

  assign mem_xfer = mem_rev_v_i & mem_rev_ready_o;
  assign host_xfer = host_rev_v_i & host_rev_ready_o;

  // Host reply older than any memory reply that shows up next
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      host_pri_r <= 1'b0;
    end
    else if (host_xfer)
    begin
      host_pri_r <= 1'b0;
    end
    else if (host_rev_v_i & (~mem_rev_v_i | mem_xfer))
    begin
      host_pri_r <= 1'b1;
    end
  end

endmodule

/* logic/nbf_loader.sv */
`timescale 1ns/1ps

module nbf_loader
  (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    input  bedrock_pkg::nbf_record_s              record_i,
    input  logic                                  record_v_i,
    output logic                                  record_ready_o,

    output bedrock_pkg::mem_fwd_s                 fwd_o,
    output logic                                  fwd_v_o,
    input  logic                                  fwd_ready_i,

    input  bedrock_pkg::mem_rev_s                 rev_i,
    input  logic                                  rev_v_i,
    output logic                                  rev_ready_o,

    output logic                                  rd_v_o,
    output logic [bedrock_pkg::paddr_width-1:0]   rd_addr_o,
    output logic [bedrock_pkg::data_width-1:0]    rd_data_o,
    output logic                                  done_o
  );

  logic [bedrock_pkg::outstanding_width-1:0] outstanding_r;
  logic                                      finish_seen_r;
  logic                                      is_msg;
  logic                                      at_limit;
  logic                                      inc;
  logic                                      dec;

  assign is_msg = (record_i.op == bedrock_pkg::e_nbf_write)
                | (record_i.op == bedrock_pkg::e_nbf_read);
  assign at_limit = (outstanding_r == bedrock_pkg::max_outstanding);

  // Finish records need no room downstream
  assign record_ready_o = ~finish_seen_r & ~at_limit & (fwd_ready_i | ~is_msg);
  assign fwd_v_o = record_v_i & is_msg & ~finish_seen_r & ~at_limit;

  always_comb
  begin
    fwd_o.msg_type = (record_i.op == bedrock_pkg::e_nbf_read) ? bedrock_pkg::e_msg_read
                                                              : bedrock_pkg::e_msg_write;
    fwd_o.addr = record_i.addr;
    fwd_o.data = record_i.data;
  end

  // Replies are always sunk
  assign rev_ready_o = 1'b1;

  assign inc = fwd_v_o & fwd_ready_i;
  assign dec = rev_v_i;

  assign done_o = finish_seen_r & (outstanding_r == '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      outstanding_r <= '0;
      finish_seen_r <= 1'b0;
      rd_v_o <= 1'b0;
    end
    else
    begin
      case ({inc, dec})
        2'b10: outstanding_r <= outstanding_r + 1'b1;
        2'b01: outstanding_r <= outstanding_r - 1'b1;
        default: outstanding_r <= outstanding_r;
      endcase
      if (record_v_i & record_ready_o & (record_i.op == bedrock_pkg::e_nbf_finish))
      begin
        finish_seen_r <= 1'b1;
      end
      rd_v_o <= rev_v_i & (rev_i.msg_type == bedrock_pkg::e_msg_read);
    end
  end

  // Read result payload
  always_ff @(posedge clk_i)
  begin
    if (rev_v_i)
    begin
      rd_addr_o <= rev_i.addr;
      rd_data_o <= rev_i.data;
    end
  end

endmodule

/* logic/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo
  #(
    parameter type msg_t = logic
  )
  (
    input  logic clk_i,
    input  logic rst_i,

    input  msg_t data_i,
    input  logic v_i,
    output logic ready_o,

    output msg_t data_o,
    output logic v_o,
    input  logic ready_i
  );

  msg_t       mem [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  assign ready_o = (count_r != 2'd2);
  assign v_o = (count_r != 2'd0);
  assign data_o = mem[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = v_o & ready_i;

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (enq)
      begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (deq)
      begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      case ({enq, deq})
        2'b10: count_r <= count_r + 2'd1;
        2'b01: count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

/* logic/bedrock_pkg.sv */
package bedrock_pkg;

  localparam int paddr_width = 20;
  localparam int data_width = 64;

  // Memory slice geometry, word index from addr[10:3]
  localparam int mem_words = 256;
  localparam int mem_index_width = $clog2(mem_words);
  localparam int mem_index_lsb = 3;

  // Host region and register offsets
  localparam int host_region_bit = 19;
  localparam int host_offset_width = 4;
  localparam logic [host_offset_width-1:0] host_trace_offset = 4'h0;
  localparam logic [host_offset_width-1:0] host_finish_offset = 4'h8;

  localparam int trace_width = 8;
  localparam int num_core = 4;

  // Loader flow control
  localparam int max_outstanding = 8;
  localparam int outstanding_width = $clog2(max_outstanding + 1);

  typedef enum logic
  {
    e_msg_read  = 1'b0,
    e_msg_write = 1'b1
  } msg_type_e;

  typedef struct packed
  {
    msg_type_e               msg_type;
    logic [paddr_width-1:0]  addr;
    logic [data_width-1:0]   data;
  } mem_fwd_s;

  typedef struct packed
  {
    msg_type_e               msg_type;
    logic [paddr_width-1:0]  addr;
    logic [data_width-1:0]   data;
  } mem_rev_s;

  typedef enum logic [1:0]
  {
    e_nbf_write  = 2'b00,
    e_nbf_read   = 2'b01,
    e_nbf_finish = 2'b10
  } nbf_op_e;

  typedef struct packed
  {
    nbf_op_e                 op;
    logic [paddr_width-1:0]  addr;
    logic [data_width-1:0]   data;
  } nbf_record_s;

endpackage
